//--- lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// datapath word, also the address width.
`define LC3B_WORD_W 16

// general purpose registers r0 to r7.
`define LC3B_NUM_REGS 8

// first fetch address once reset is released.
`define LC3B_PC_RESET 16'h0000

`endif

//--- lc3b_pkg.sv
`include "lc3b_cfg.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;   // n, z, p from msb down.

    // only the opcodes this core executes.
    typedef enum logic [3:0] {
        lc3b_op_br  = 4'b0000,
        lc3b_op_add = 4'b0001,
        lc3b_op_and = 4'b0101,
        lc3b_op_ldr = 4'b0110,
        lc3b_op_str = 4'b0111,
        lc3b_op_not = 4'b1001,
        lc3b_op_jmp = 4'b1100
    } lc3b_opcode;

    typedef enum logic [1:0] {
        lc3b_pc_mux_sel_pc_plus2,
        lc3b_pc_mux_sel_pcn,    // pc-relative branch target.
        lc3b_pc_mux_sel_sr1     // base register of a jmp.
    } lc3b_pc_mux_sel;

    typedef enum logic {
        lc3b_wb_sel_alu,
        lc3b_wb_sel_mdr
    } lc3b_wb_sel;

    typedef enum logic [1:0] {
        lc3b_alu_add,
        lc3b_alu_and,
        lc3b_alu_not,
        lc3b_alu_pass_b
    } lc3b_alu_op;

    typedef struct packed {
        lc3b_opcode     opcode;
        lc3b_alu_op     alu_op;
        logic           imm_sel;    // immediate instead of sr2.
        lc3b_pc_mux_sel pc_mux_sel;
        logic           conditional_branch;
        logic           mem_read;
        logic           mem_write;
        lc3b_wb_sel     wb_sel;
        logic           regfile_load;
        lc3b_reg        dest;
    } lc3b_control_word;

endpackage

//--- lc3b_pipe_if.sv
// one pipeline barrier; fields not yet known by the filling stage are zero.
interface lc3b_pipe_if;

    logic                        valid;
    lc3b_pkg::lc3b_control_word  control;
    lc3b_pkg::lc3b_word          ir;
    lc3b_pkg::lc3b_word          pc;     // already pc + 2.
    lc3b_pkg::lc3b_word          sr1;
    lc3b_pkg::lc3b_word          sr2;
    lc3b_pkg::lc3b_word          alu;
    lc3b_pkg::lc3b_word          pcn;
    lc3b_pkg::lc3b_word          mdr;

    modport producer (
        output valid, control, ir, pc, sr1, sr2, alu, pcn, mdr
    );

    modport consumer (
        input valid, control, ir, pc, sr1, sr2, alu, pcn, mdr
    );

endinterface

//--- stage_fetch.sv
`include "lc3b_cfg.svh"

module stage_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                br_en,
    lc3b_pipe_if.consumer       wb,
    output lc3b_pkg::lc3b_word  imem_addr,
    input  lc3b_pkg::lc3b_word  imem_rdata,
    lc3b_pipe_if.producer       if_id
);

    lc3b_pkg::lc3b_word       pc;
    lc3b_pkg::lc3b_word       pc_plus2;
    lc3b_pkg::lc3b_word       next_pc;
    lc3b_pkg::lc3b_pc_mux_sel pc_mux_sel;

    assign pc_plus2  = pc + 16'd2;
    assign imem_addr = pc;  // only moves on a clock edge.

    // redirect comes from the entry sitting in mem_wb.
    always_comb begin
        pc_mux_sel = lc3b_pkg::lc3b_pc_mux_sel_pc_plus2;
        if (wb.valid) begin
            pc_mux_sel = wb.control.pc_mux_sel;
            if (wb.control.conditional_branch && !br_en) begin
                pc_mux_sel = lc3b_pkg::lc3b_pc_mux_sel_pc_plus2;  // not taken.
            end
        end
    end

    always_comb begin
        case (pc_mux_sel)
            lc3b_pkg::lc3b_pc_mux_sel_pcn: next_pc = wb.pcn;
            lc3b_pkg::lc3b_pc_mux_sel_sr1: next_pc = wb.sr1;
            default:                       next_pc = pc_plus2;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= `LC3B_PC_RESET;
            if_id.valid  <= 1'b0;
        end else begin
            pc           <= next_pc;
            if_id.valid  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if_id.ir <= imem_rdata;
        if_id.pc <= pc_plus2;
    end

    // nothing decoded yet.
    assign if_id.control = '0;
    assign if_id.sr1     = '0;
    assign if_id.sr2     = '0;
    assign if_id.alu     = '0;
    assign if_id.pcn     = '0;
    assign if_id.mdr     = '0;

endmodule

//--- stage_decode.sv
`include "lc3b_cfg.svh"

module stage_decode (
    input  logic          clk,
    input  logic          rst_n,
    lc3b_pipe_if.consumer if_id,
    lc3b_pipe_if.consumer wb,
    lc3b_pipe_if.producer id_ex
);

    lc3b_pkg::lc3b_word         ir;
    lc3b_pkg::lc3b_control_word ctrl;
    lc3b_pkg::lc3b_reg          sr1_addr;
    lc3b_pkg::lc3b_reg          sr2_addr;
    lc3b_pkg::lc3b_word         sr1;
    lc3b_pkg::lc3b_word         sr2;
    lc3b_pkg::lc3b_word         wb_data;
    logic                       wb_load;

    lc3b_pkg::lc3b_word         regs [`LC3B_NUM_REGS];

    // an empty slot decodes as the all-zero word, a br that never branches.
    assign ir = if_id.valid ? if_id.ir : '0;

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = lc3b_pkg::lc3b_opcode'(ir[15:12]);
        ctrl.alu_op = lc3b_pkg::lc3b_alu_pass_b;
        ctrl.dest   = ir[11:9];
        case (ctrl.opcode)
            lc3b_pkg::lc3b_op_add, lc3b_pkg::lc3b_op_and: begin
                ctrl.alu_op       = (ctrl.opcode == lc3b_pkg::lc3b_op_add) ?
                                    lc3b_pkg::lc3b_alu_add : lc3b_pkg::lc3b_alu_and;
                ctrl.imm_sel      = ir[5];  // imm5 form.
                ctrl.regfile_load = 1'b1;
            end
            lc3b_pkg::lc3b_op_not: begin
                ctrl.alu_op       = lc3b_pkg::lc3b_alu_not;
                ctrl.regfile_load = 1'b1;
            end
            lc3b_pkg::lc3b_op_ldr: begin
                ctrl.alu_op       = lc3b_pkg::lc3b_alu_add;
                ctrl.imm_sel      = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.wb_sel       = lc3b_pkg::lc3b_wb_sel_mdr;
                ctrl.regfile_load = 1'b1;
            end
            lc3b_pkg::lc3b_op_str: begin
                ctrl.alu_op    = lc3b_pkg::lc3b_alu_add;
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            lc3b_pkg::lc3b_op_br: begin
                ctrl.pc_mux_sel         = lc3b_pkg::lc3b_pc_mux_sel_pcn;
                ctrl.conditional_branch = 1'b1;
            end
            lc3b_pkg::lc3b_op_jmp: begin
                ctrl.pc_mux_sel = lc3b_pkg::lc3b_pc_mux_sel_sr1;
            end
            default: ;  // unsupported opcodes do nothing.
        endcase
    end

    assign sr1_addr = ir[8:6];
    // str reads its data register from the dest field.
    assign sr2_addr = (ctrl.opcode == lc3b_pkg::lc3b_op_str) ? ir[11:9] : ir[2:0];

    assign wb_load = wb.valid && wb.control.regfile_load;
    assign wb_data = (wb.control.wb_sel == lc3b_pkg::lc3b_wb_sel_mdr) ? wb.mdr : wb.alu;

    always_ff @(posedge clk) begin
        if (wb_load) begin
            regs[wb.control.dest] <= wb_data;
        end
    end

    // write-before-read bypass.
    always_comb begin
        sr1 = regs[sr1_addr];
        sr2 = regs[sr2_addr];
        if (wb_load && wb.control.dest == sr1_addr) begin
            sr1 = wb_data;
        end
        if (wb_load && wb.control.dest == sr2_addr) begin
            sr2 = wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid   <= 1'b0;
            id_ex.control <= '0;
        end else begin
            id_ex.valid   <= if_id.valid;
            id_ex.control <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.ir  <= if_id.ir;
        id_ex.pc  <= if_id.pc;
        id_ex.sr1 <= sr1;
        id_ex.sr2 <= sr2;
    end

    assign id_ex.alu = '0;
    assign id_ex.pcn = '0;
    assign id_ex.mdr = '0;

endmodule

//--- stage_execute.sv
`include "lc3b_cfg.svh"

module stage_execute (
    input  logic          clk,
    input  logic          rst_n,
    lc3b_pipe_if.consumer id_ex,
    lc3b_pipe_if.producer ex_mem
);

    lc3b_pkg::lc3b_word imm5;
    lc3b_pkg::lc3b_word offset6;
    lc3b_pkg::lc3b_word offset9;
    lc3b_pkg::lc3b_word alu_b;
    lc3b_pkg::lc3b_word alu;
    lc3b_pkg::lc3b_word pcn;
    logic               mem_op;

    assign imm5    = {{(`LC3B_WORD_W-5){id_ex.ir[4]}}, id_ex.ir[4:0]};
    // word offsets, scaled to bytes.
    assign offset6 = {{(`LC3B_WORD_W-7){id_ex.ir[5]}}, id_ex.ir[5:0], 1'b0};
    assign offset9 = {{(`LC3B_WORD_W-10){id_ex.ir[8]}}, id_ex.ir[8:0], 1'b0};

    assign mem_op = id_ex.control.mem_read || id_ex.control.mem_write;

    always_comb begin
        if (!id_ex.control.imm_sel) begin
            alu_b = id_ex.sr2;
        end else if (mem_op) begin
            alu_b = offset6;   // base + offset address.
        end else begin
            alu_b = imm5;
        end
    end

    always_comb begin
        case (id_ex.control.alu_op)
            lc3b_pkg::lc3b_alu_add: alu = id_ex.sr1 + alu_b;
            lc3b_pkg::lc3b_alu_and: alu = id_ex.sr1 & alu_b;
            lc3b_pkg::lc3b_alu_not: alu = ~id_ex.sr1;
            default:                alu = alu_b;
        endcase
    end

    assign pcn = id_ex.pc + offset9;  // pc here is already pc + 2.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.valid   <= 1'b0;
            ex_mem.control <= '0;
        end else begin
            ex_mem.valid   <= id_ex.valid;
            ex_mem.control <= id_ex.control;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.ir  <= id_ex.ir;
        ex_mem.pc  <= id_ex.pc;
        ex_mem.sr1 <= id_ex.sr1;   // jmp target rides along.
        ex_mem.sr2 <= id_ex.sr2;
        ex_mem.alu <= alu;
        ex_mem.pcn <= pcn;
    end

    assign ex_mem.mdr = '0;

endmodule

//--- stage_memory.sv
module stage_memory (
    input  logic                clk,
    input  logic                rst_n,
    lc3b_pipe_if.consumer       ex_mem,
    output logic                dmem_strobe,
    output logic                dmem_we,
    output lc3b_pkg::lc3b_word  dmem_addr,
    output lc3b_pkg::lc3b_word  dmem_wdata,
    input  lc3b_pkg::lc3b_word  dmem_rdata,
    output logic                br_en,
    lc3b_pipe_if.producer       mem_wb
);

    lc3b_pkg::lc3b_nzp  nzp;
    lc3b_pkg::lc3b_word result;
    logic               taken;

    // single cycle access, the memory answers in the same cycle.
    assign dmem_strobe = ex_mem.valid && (ex_mem.control.mem_read || ex_mem.control.mem_write);
    assign dmem_we     = ex_mem.valid && ex_mem.control.mem_write;
    assign dmem_addr   = ex_mem.alu;
    assign dmem_wdata  = ex_mem.sr2;

    assign result = ex_mem.control.mem_read ? dmem_rdata : ex_mem.alu;

    // branch nzp field against the current flags.
    assign taken = ex_mem.valid && ex_mem.control.conditional_branch &&
                   |(ex_mem.ir[11:9] & nzp);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nzp            <= '0;
            br_en          <= 1'b0;
            mem_wb.valid   <= 1'b0;
            mem_wb.control <= '0;
        end else begin
            if (ex_mem.valid && ex_mem.control.regfile_load) begin
                nzp <= {result[15], result == '0, !result[15] && result != '0};
            end
            br_en          <= taken;  // lines up with the mem_wb entry.
            mem_wb.valid   <= ex_mem.valid;
            mem_wb.control <= ex_mem.control;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb.ir  <= ex_mem.ir;
        mem_wb.pc  <= ex_mem.pc;
        mem_wb.sr1 <= ex_mem.sr1;
        mem_wb.sr2 <= ex_mem.sr2;
        mem_wb.alu <= ex_mem.alu;
        mem_wb.pcn <= ex_mem.pcn;
        mem_wb.mdr <= dmem_rdata;
    end

endmodule

//--- lc3b_core.sv
module lc3b_core (
    input  logic                clk,
    input  logic                rst_n,

    // instruction memory.
    output lc3b_pkg::lc3b_word  imem_addr,
    input  lc3b_pkg::lc3b_word  imem_rdata,

    // data memory.
    output logic                dmem_strobe,
    output logic                dmem_we,
    output lc3b_pkg::lc3b_word  dmem_addr,
    output lc3b_pkg::lc3b_word  dmem_wdata,
    input  lc3b_pkg::lc3b_word  dmem_rdata
);

    logic br_en;

    lc3b_pipe_if if_id ();
    lc3b_pipe_if id_ex ();
    lc3b_pipe_if ex_mem ();
    lc3b_pipe_if mem_wb ();

    stage_fetch u_fetch (
        .clk,
        .rst_n,
        .br_en,
        .wb         (mem_wb),
        .imem_addr,
        .imem_rdata,
        .if_id      (if_id)
    );

    // also holds the register file written from mem_wb.
    stage_decode u_decode (
        .clk,
        .rst_n,
        .if_id      (if_id),
        .wb         (mem_wb),
        .id_ex      (id_ex)
    );

    stage_execute u_execute (
        .clk,
        .rst_n,
        .id_ex      (id_ex),
        .ex_mem     (ex_mem)
    );

    stage_memory u_memory (
        .clk,
        .rst_n,
        .ex_mem     (ex_mem),
        .dmem_strobe,
        .dmem_we,
        .dmem_addr,
        .dmem_wdata,
        .dmem_rdata,
        .br_en,
        .mem_wb     (mem_wb)
    );

endmodule

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 5;  // 10 ns clock.
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;  // released on a rising edge.
    end

endmodule

//--- tb_lc3b_core.sv
`include "lc3b_cfg.svh"

module tb_lc3b_core;

    timeunit 1ns;
    timeprecision 100ps;

    // word offsets of the regions inside the case file.
    localparam int count_base = 'h000;
    localparam int prog_base  = 'h010;
    localparam int data_base  = 'h100;
    localparam int store_base = 'h180;
    localparam int mem_words  = 256;

    logic               clk;
    logic               rst_n;
    lc3b_pkg::lc3b_word imem_addr;
    lc3b_pkg::lc3b_word imem_rdata;
    logic               dmem_strobe;
    logic               dmem_we;
    lc3b_pkg::lc3b_word dmem_addr;
    lc3b_pkg::lc3b_word dmem_wdata;
    lc3b_pkg::lc3b_word dmem_rdata;

    lc3b_pkg::lc3b_word cases [512];
    lc3b_pkg::lc3b_word imem [mem_words];
    lc3b_pkg::lc3b_word dmem [mem_words];

    int prog_len = 0;
    int data_cnt = 0;
    int store_cnt = 0;
    int stores_seen = 0;
    int cycles_run = 0;     // cycles since reset was released.
    int value_errors = 0;
    int other_errors = 0;

    tb_clock u_clock (
        .clk,
        .rst_n
    );

    lc3b_core i_dut (
        .clk,
        .rst_n,
        .imem_addr,
        .imem_rdata,
        .dmem_strobe,
        .dmem_we,
        .dmem_addr,
        .dmem_wdata,
        .dmem_rdata
    );

    // both memories answer in the same cycle and are word indexed.
    assign imem_rdata = imem[imem_addr[8:1]];
    assign dmem_rdata = dmem[dmem_addr[8:1]];

    task automatic check_addr(input string name, input lc3b_pkg::lc3b_word expected,
                              input lc3b_pkg::lc3b_word actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_data(input string name, input lc3b_pkg::lc3b_word expected,
                              input lc3b_pkg::lc3b_word actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_cases();
        lc3b_pkg::lc3b_word addr;
        void'($urandom(32'h9885_ca37));
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = '0;                              // nop fill.
            dmem[i] <= lc3b_pkg::lc3b_word'($urandom);  // unused data is noise.
        end
        $readmemh("lc3b_core_cases.txt", cases);
        prog_len  = int'(cases[count_base]);
        data_cnt  = int'(cases[count_base + 1]);
        store_cnt = int'(cases[count_base + 2]);
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = cases[prog_base + i];
        end
        for (int i = 0; i < data_cnt; i++) begin
            addr = cases[data_base + 2 * i];
            dmem[addr[8:1]] <= cases[data_base + 2 * i + 1];
        end
    endtask

    // reset checks first and then every store in list order.
    always @(posedge clk) begin
        if (!rst_n) begin
            check_flag("dmem_strobe", 1'b0, dmem_strobe);
        end else begin
            if (cycles_run == 0) begin
                check_addr("imem_addr", `LC3B_PC_RESET, imem_addr);
            end
            if (cycles_run < 4) begin
                check_flag("dmem_strobe", 1'b0, dmem_strobe);
            end
            cycles_run <= cycles_run + 1;
            if (dmem_strobe && dmem_we) begin
                if (stores_seen < store_cnt) begin
                    check_addr("dmem_addr", cases[store_base + 2 * stores_seen], dmem_addr);
                    check_data("dmem_wdata", cases[store_base + 2 * stores_seen + 1],
                               dmem_wdata);
                end else begin
                    $display("store of %h to %h at %0t ns was not expected",
                             dmem_wdata, dmem_addr, $time);
                    other_errors++;
                end
                stores_seen++;
                dmem[dmem_addr[8:1]] <= dmem_wdata;
            end
        end
    end

    initial begin
        load_cases();
        if (prog_len == 0 || store_cnt == 0) begin
            $display("case file lc3b_core_cases.txt is missing or empty");
            other_errors++;
            $display("%0d mismatches, %0d other errors, %0d of %0d stores seen",
                     value_errors, other_errors, stores_seen, store_cnt);
            $display("=== FAIL ===");
            $finish;
        end else begin
            @(negedge clk);
            wait (rst_n === 1'b1);
            while (stores_seen < store_cnt) @(negedge clk);
            repeat (20) @(negedge clk);  // room for a stray store.
            $display("%0d mismatches, %0d other errors, %0d of %0d stores seen",
                     value_errors, other_errors, stores_seen, store_cnt);
            if (value_errors == 0 && other_errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

    // watchdog sized from the program length.
    initial begin
        int i;
        @(negedge clk);
        wait (rst_n === 1'b1);
        repeat ((prog_len + 20) * 10) @(posedge clk);
        $display("timeout at %0t ns, the program did not reach all of its stores", $time);
        for (i = stores_seen; i < store_cnt; i++) begin
            $display("store %0d of %h to %h was never seen",
                     i, cases[store_base + 2 * i + 1], cases[store_base + 2 * i]);
        end
        $display("%0d mismatches, %0d other errors, %0d of %0d stores seen",
                 value_errors, other_errors, stores_seen, store_cnt);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- lc3b_core_cases.txt
// hex words for $readmemh, each @ gives the word index of the next region.
// @000 program word count, data word count, expected store count.
// @010 program words from byte address 0000, eight per line.
// @100 data preload as byte address, value pairs.
// @180 expected stores in order as byte address, value pairs.
@000
0047 0003 000E
@010
5FE0 5260 54A0 56E0 1265 14BD 16EC 0000 // clear and seed r7, r1, r2, r3
1842 5A43 9CBF 73C0 75C1 79C2 7BC3 7DC4 // add, and, not register forms
52AE 98FF 1A82 73C5 79C6 7BC7 63DE 0000 // immediate forms, then ldr r1
0000 1467 0000 0000 75C8 67DF 0805 0000 // loaded word plus 7, brn
0000 0000 0000 7DD4 77C9 5920 0405 0000 // wrong path store, brz
0000 0000 0000 7DD5 79CA 1B29 0205 0000 // wrong path store, brp
0000 0000 0000 7DD6 7BCB 0C05 0000 0000 // wrong path store, brnz untaken
0000 0000 73CC 65DD 0000 0000 C080 0000 // fall-through store, jmp r2
0000 0000 0000 7DD7 7DD8 75CD 0FFF      // skipped stores, target, loop
@100
003A 008A 003C 1234 003E 8001
@180
0000 0005 0002 FFFD 0004 0002 0006 0004
0008 0002 000A 000C 000C FFF3 000E FFFA
0010 123B 0012 8001 0014 0000 0016 0009
0018 1234 001A 008A

//--- lc3b_core.f
+incdir+.
lc3b_pkg.sv
lc3b_pipe_if.sv
stage_fetch.sv
stage_decode.sv
stage_execute.sv
stage_memory.sv
lc3b_core.sv
tb_clock.sv
tb_lc3b_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lc3b_core
FILELIST  ?= lc3b_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
